// ==== logic/issue_pkg.sv ====
// Issue stage package with data widths, scoreboard size and FU and operation codes
package issue_pkg;

    // ------------------------------
    // Data path and register file
    // ------------------------------
    localparam int unsigned XLEN          = 32;
    localparam int unsigned NR_REGS       = 32;
    localparam int unsigned REG_ADDR_BITS = 5;

    // ------------------------------
    // Scoreboard
    // ------------------------------
    localparam int unsigned NR_SB_ENTRIES = 4;
    // Transaction id is a scoreboard index
    localparam int unsigned TRANS_ID_BITS = 2;
    // Port 0 is the ALU, port 1 the multiplier
    localparam int unsigned NR_WB_PORTS   = 2;

    // ------------------------------
    // Functional units and operations
    // ------------------------------
    localparam logic FU_ALU = 1'b0;
    localparam logic FU_MUL = 1'b1;

    localparam int unsigned OP_BITS = 3;

    localparam logic [OP_BITS-1:0] OP_ADD = 3'd0;
    localparam logic [OP_BITS-1:0] OP_SUB = 3'd1;
    localparam logic [OP_BITS-1:0] OP_AND = 3'd2;
    localparam logic [OP_BITS-1:0] OP_XOR = 3'd3;
    // Only op that goes to the multiplier
    localparam logic [OP_BITS-1:0] OP_MUL = 3'd4;

endpackage

// ==== logic/issue_read_operands.sv ====
// Hazard check, operand selection and registered dispatch to the ALU and multiplier
`timescale 1ns/1ns

module issue_read_operands (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  logic                                flush_i,
    input  logic                                sb_full_i,
    // Decoded instruction
    input  logic                                decoded_valid_i,
    input  logic [issue_pkg::OP_BITS-1:0]       op_i,
    input  logic [issue_pkg::REG_ADDR_BITS-1:0] rs1_i,
    input  logic [issue_pkg::REG_ADDR_BITS-1:0] rs2_i,
    input  logic [issue_pkg::XLEN-1:0]          imm_i,
    input  logic                                use_imm_i,
    output logic                                decoded_ack_o,
    output logic                                stall_issue_o,
    // Scoreboard
    output logic                                issue_ack_o,
    input  logic [issue_pkg::TRANS_ID_BITS-1:0] issue_trans_id_i,
    output logic [issue_pkg::REG_ADDR_BITS-1:0] rs1_addr_o,
    input  logic                                rs1_clobber_i,
    input  logic                                rs1_valid_i,
    input  logic [issue_pkg::XLEN-1:0]          rs1_data_i,
    output logic [issue_pkg::REG_ADDR_BITS-1:0] rs2_addr_o,
    input  logic                                rs2_clobber_i,
    input  logic                                rs2_valid_i,
    input  logic [issue_pkg::XLEN-1:0]          rs2_data_i,
    // Functional units
    input  logic                                alu_ready_i,
    input  logic                                mul_ready_i,
    output logic                                alu_valid_o,
    output logic                                mul_valid_o,
    output logic [issue_pkg::OP_BITS-1:0]       fu_op_o,
    output logic [issue_pkg::XLEN-1:0]          operand_a_o,
    output logic [issue_pkg::XLEN-1:0]          operand_b_o,
    output logic [issue_pkg::TRANS_ID_BITS-1:0] trans_id_o,
    // Commit write into the register file
    input  logic                                commit_ack_i,
    input  logic [issue_pkg::REG_ADDR_BITS-1:0] commit_rd_i,
    input  logic [issue_pkg::XLEN-1:0]          commit_result_i
);
    import issue_pkg::*;

    logic            fu_sel;
    logic            fu_ready;
    logic            rs1_hazard;
    logic            rs2_hazard;
    logic [XLEN-1:0] rf_a;
    logic [XLEN-1:0] rf_b;
    logic [XLEN-1:0] operand_a;
    logic [XLEN-1:0] operand_b;

    assign rs1_addr_o = rs1_i;
    assign rs2_addr_o = rs2_i;

    // ------------------------------
    // Hazard and ready check
    // ------------------------------
    // Waiting on a producer that has not written back yet
    assign rs1_hazard = rs1_clobber_i & ~rs1_valid_i;
    assign rs2_hazard = rs2_clobber_i & ~rs2_valid_i & ~use_imm_i;

    assign fu_sel   = (op_i == OP_MUL) ? FU_MUL : FU_ALU;
    assign fu_ready = (fu_sel == FU_MUL) ? mul_ready_i : alu_ready_i;

    assign decoded_ack_o = ~sb_full_i & ~flush_i & ~rs1_hazard & ~rs2_hazard & fu_ready;
    assign issue_ack_o   = decoded_valid_i & decoded_ack_o;
    assign stall_issue_o = decoded_valid_i & ~decoded_ack_o;

    // ------------------------------
    // Operand read
    // ------------------------------
    regfile i_regfile (
        .clk_i     ( clk_i           ),
        .rst_i     ( rst_i           ),
        .raddr_a_i ( rs1_i           ),
        .rdata_a_o ( rf_a            ),
        .raddr_b_i ( rs2_i           ),
        .rdata_b_o ( rf_b            ),
        .we_i      ( commit_ack_i    ),
        .waddr_i   ( commit_rd_i     ),
        .wdata_i   ( commit_result_i )
    );

    // Forwarded value takes priority over the architectural one
    assign operand_a = rs1_clobber_i ? rs1_data_i : rf_a;
    assign operand_b = use_imm_i     ? imm_i
                     : rs2_clobber_i ? rs2_data_i : rf_b;

    // ------------------------------
    // Dispatch registers
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            alu_valid_o <= 1'b0;
            mul_valid_o <= 1'b0;
        end else begin
            // One cycle pulse per accepted instruction
            alu_valid_o <= issue_ack_o & (fu_sel == FU_ALU);
            mul_valid_o <= issue_ack_o & (fu_sel == FU_MUL);
        end
    end

    always_ff @(posedge clk_i) begin
        if (issue_ack_o) begin
            fu_op_o     <= op_i;
            operand_a_o <= operand_a;
            operand_b_o <= operand_b;
            trans_id_o  <= issue_trans_id_i;
        end
    end

endmodule

// ==== logic/issue_stage.sv ====
// Issue stage top, scoreboard plus operand read and dispatch
`timescale 1ns/1ns

module issue_stage (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  logic                                flush_i,
    output logic                                sb_full_o,
    output logic                                stall_issue_o,
    // Decode side
    input  logic                                decoded_valid_i,
    input  logic [issue_pkg::OP_BITS-1:0]       op_i,
    input  logic [issue_pkg::REG_ADDR_BITS-1:0] rd_i,
    input  logic [issue_pkg::REG_ADDR_BITS-1:0] rs1_i,
    input  logic [issue_pkg::REG_ADDR_BITS-1:0] rs2_i,
    input  logic [issue_pkg::XLEN-1:0]          imm_i,
    input  logic                                use_imm_i,
    output logic                                decoded_ack_o,
    // Functional units
    input  logic                                alu_ready_i,
    input  logic                                mul_ready_i,
    output logic                                alu_valid_o,
    output logic                                mul_valid_o,
    output logic [issue_pkg::OP_BITS-1:0]       fu_op_o,
    output logic [issue_pkg::XLEN-1:0]          operand_a_o,
    output logic [issue_pkg::XLEN-1:0]          operand_b_o,
    output logic [issue_pkg::TRANS_ID_BITS-1:0] trans_id_o,
    // Writeback
    input  logic [issue_pkg::NR_WB_PORTS-1:0]   wt_valid_i,
    input  logic [issue_pkg::NR_WB_PORTS-1:0][issue_pkg::TRANS_ID_BITS-1:0] trans_id_i,
    input  logic [issue_pkg::NR_WB_PORTS-1:0][issue_pkg::XLEN-1:0]          wbdata_i,
    // Commit
    output logic                                commit_valid_o,
    output logic [issue_pkg::REG_ADDR_BITS-1:0] commit_rd_o,
    output logic [issue_pkg::XLEN-1:0]          commit_result_o,
    output logic [issue_pkg::TRANS_ID_BITS-1:0] commit_trans_id_o,
    input  logic                                commit_ack_i
);
    import issue_pkg::*;

    // ------------------------------
    // Scoreboard <-> operand read
    // ------------------------------
    logic                     issue_ack;
    logic [TRANS_ID_BITS-1:0] issue_trans_id;
    logic [REG_ADDR_BITS-1:0] rs1_addr;
    logic                     rs1_clobber;
    logic                     rs1_valid;
    logic [XLEN-1:0]          rs1_data;
    logic [REG_ADDR_BITS-1:0] rs2_addr;
    logic                     rs2_clobber;
    logic                     rs2_valid;
    logic [XLEN-1:0]          rs2_data;

    scoreboard i_scoreboard (
        .clk_i             ( clk_i             ),
        .rst_i             ( rst_i             ),
        .flush_i           ( flush_i           ),
        .sb_full_o         ( sb_full_o         ),
        .issue_ack_i       ( issue_ack         ),
        .issue_rd_i        ( rd_i              ),
        .issue_trans_id_o  ( issue_trans_id    ),
        .rs1_addr_i        ( rs1_addr          ),
        .rs1_clobber_o     ( rs1_clobber       ),
        .rs1_valid_o       ( rs1_valid         ),
        .rs1_data_o        ( rs1_data          ),
        .rs2_addr_i        ( rs2_addr          ),
        .rs2_clobber_o     ( rs2_clobber       ),
        .rs2_valid_o       ( rs2_valid         ),
        .rs2_data_o        ( rs2_data          ),
        .wt_valid_i        ( wt_valid_i        ),
        .trans_id_i        ( trans_id_i        ),
        .wbdata_i          ( wbdata_i          ),
        .commit_valid_o    ( commit_valid_o    ),
        .commit_rd_o       ( commit_rd_o       ),
        .commit_result_o   ( commit_result_o   ),
        .commit_trans_id_o ( commit_trans_id_o ),
        .commit_ack_i      ( commit_ack_i      )
    );

    issue_read_operands i_issue_read_operands (
        .clk_i            ( clk_i           ),
        .rst_i            ( rst_i           ),
        .flush_i          ( flush_i         ),
        .sb_full_i        ( sb_full_o       ),
        .decoded_valid_i  ( decoded_valid_i ),
        .op_i             ( op_i            ),
        .rs1_i            ( rs1_i           ),
        .rs2_i            ( rs2_i           ),
        .imm_i            ( imm_i           ),
        .use_imm_i        ( use_imm_i       ),
        .decoded_ack_o    ( decoded_ack_o   ),
        .stall_issue_o    ( stall_issue_o   ),
        .issue_ack_o      ( issue_ack       ),
        .issue_trans_id_i ( issue_trans_id  ),
        .rs1_addr_o       ( rs1_addr        ),
        .rs1_clobber_i    ( rs1_clobber     ),
        .rs1_valid_i      ( rs1_valid       ),
        .rs1_data_i       ( rs1_data        ),
        .rs2_addr_o       ( rs2_addr        ),
        .rs2_clobber_i    ( rs2_clobber     ),
        .rs2_valid_i      ( rs2_valid       ),
        .rs2_data_i       ( rs2_data        ),
        .alu_ready_i      ( alu_ready_i     ),
        .mul_ready_i      ( mul_ready_i     ),
        .alu_valid_o      ( alu_valid_o     ),
        .mul_valid_o      ( mul_valid_o     ),
        .fu_op_o          ( fu_op_o         ),
        .operand_a_o      ( operand_a_o     ),
        .operand_b_o      ( operand_b_o     ),
        .trans_id_o       ( trans_id_o      ),
        .commit_ack_i     ( commit_ack_i    ),
        .commit_rd_i      ( commit_rd_o     ),
        .commit_result_i  ( commit_result_o )
    );

endmodule

// ==== logic/regfile.sv ====
// Architectural register file, two combinational reads and one write, x0 tied to zero
`timescale 1ns/1ns

module regfile (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  logic [issue_pkg::REG_ADDR_BITS-1:0] raddr_a_i,
    output logic [issue_pkg::XLEN-1:0]          rdata_a_o,
    input  logic [issue_pkg::REG_ADDR_BITS-1:0] raddr_b_i,
    output logic [issue_pkg::XLEN-1:0]          rdata_b_o,
    input  logic                                we_i,
    input  logic [issue_pkg::REG_ADDR_BITS-1:0] waddr_i,
    input  logic [issue_pkg::XLEN-1:0]          wdata_i
);
    import issue_pkg::*;

    logic [NR_REGS-1:0][XLEN-1:0] regs_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            regs_q <= '0;
        end else if (we_i && waddr_i != '0) begin
            // Writes to x0 are dropped
            regs_q[waddr_i] <= wdata_i;
        end
    end

    assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

// ==== logic/scoreboard.sv ====
// Scoreboard tracking in-flight instructions with operand lookup and in-order commit
`timescale 1ns/1ns

module scoreboard (
    input  logic                                    clk_i,
    input  logic                                    rst_i,
    input  logic                                    flush_i,
    output logic                                    sb_full_o,
    // Allocation on issue
    input  logic                                    issue_ack_i,
    input  logic [issue_pkg::REG_ADDR_BITS-1:0]     issue_rd_i,
    output logic [issue_pkg::TRANS_ID_BITS-1:0]     issue_trans_id_o,
    // Operand lookup
    input  logic [issue_pkg::REG_ADDR_BITS-1:0]     rs1_addr_i,
    output logic                                    rs1_clobber_o,
    output logic                                    rs1_valid_o,
    output logic [issue_pkg::XLEN-1:0]              rs1_data_o,
    input  logic [issue_pkg::REG_ADDR_BITS-1:0]     rs2_addr_i,
    output logic                                    rs2_clobber_o,
    output logic                                    rs2_valid_o,
    output logic [issue_pkg::XLEN-1:0]              rs2_data_o,
    // Writeback ports
    input  logic [issue_pkg::NR_WB_PORTS-1:0]       wt_valid_i,
    input  logic [issue_pkg::NR_WB_PORTS-1:0][issue_pkg::TRANS_ID_BITS-1:0] trans_id_i,
    input  logic [issue_pkg::NR_WB_PORTS-1:0][issue_pkg::XLEN-1:0]          wbdata_i,
    // Commit port
    output logic                                    commit_valid_o,
    output logic [issue_pkg::REG_ADDR_BITS-1:0]     commit_rd_o,
    output logic [issue_pkg::XLEN-1:0]              commit_result_o,
    output logic [issue_pkg::TRANS_ID_BITS-1:0]     commit_trans_id_o,
    input  logic                                    commit_ack_i
);
    import issue_pkg::*;

    logic [NR_SB_ENTRIES-1:0]                    busy_q;
    logic [NR_SB_ENTRIES-1:0]                    done_q;
    logic [NR_SB_ENTRIES-1:0][REG_ADDR_BITS-1:0] rd_q;
    logic [NR_SB_ENTRIES-1:0][XLEN-1:0]          result_q;

    logic [TRANS_ID_BITS-1:0] head_q;
    logic [TRANS_ID_BITS-1:0] tail_q;
    logic [TRANS_ID_BITS:0]   count_q;

    // Entry state with this cycle's writebacks already folded in
    logic [NR_SB_ENTRIES-1:0]           done_merged;
    logic [NR_SB_ENTRIES-1:0][XLEN-1:0] result_merged;

    logic commit_pop;

    assign sb_full_o        = (count_q == (TRANS_ID_BITS+1)'(NR_SB_ENTRIES));
    assign issue_trans_id_o = tail_q;

    // ------------------------------
    // Writeback merge
    // ------------------------------
    always_comb begin
        done_merged   = done_q;
        result_merged = result_q;
        for (int p = 0; p < NR_WB_PORTS; p++) begin
            if (wt_valid_i[p] && busy_q[trans_id_i[p]]) begin
                done_merged[trans_id_i[p]]   = 1'b1;
                result_merged[trans_id_i[p]] = wbdata_i[p];
            end
        end
    end

    // ------------------------------
    // Operand lookup
    // ------------------------------
    // Walk oldest to youngest so the youngest producer overrides older ones
    always_comb begin : lookup
        logic [TRANS_ID_BITS-1:0] idx;
        rs1_clobber_o = 1'b0;
        rs1_valid_o   = 1'b0;
        rs1_data_o    = '0;
        rs2_clobber_o = 1'b0;
        rs2_valid_o   = 1'b0;
        rs2_data_o    = '0;
        for (int k = 0; k < NR_SB_ENTRIES; k++) begin
            idx = head_q + TRANS_ID_BITS'(k);
            // x0 is never clobbered, its value is always zero
            if (busy_q[idx] && rd_q[idx] == rs1_addr_i && rs1_addr_i != '0) begin
                rs1_clobber_o = 1'b1;
                rs1_valid_o   = done_merged[idx];
                rs1_data_o    = result_merged[idx];
            end
            if (busy_q[idx] && rd_q[idx] == rs2_addr_i && rs2_addr_i != '0) begin
                rs2_clobber_o = 1'b1;
                rs2_valid_o   = done_merged[idx];
                rs2_data_o    = result_merged[idx];
            end
        end
    end

    // ------------------------------
    // Commit
    // ------------------------------
    assign commit_valid_o    = busy_q[head_q] & done_merged[head_q];
    assign commit_rd_o       = rd_q[head_q];
    assign commit_result_o   = result_merged[head_q];
    assign commit_trans_id_o = head_q;
    assign commit_pop        = commit_ack_i & commit_valid_o;

    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            busy_q  <= '0;
            done_q  <= '0;
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            done_q <= done_merged;
            if (issue_ack_i) begin
                busy_q[tail_q] <= 1'b1;
                done_q[tail_q] <= 1'b0;
                tail_q         <= tail_q + 1'b1;
            end
            if (commit_pop) begin
                busy_q[head_q] <= 1'b0;
                head_q         <= head_q + 1'b1;
            end
            count_q <= count_q + {{TRANS_ID_BITS{1'b0}}, issue_ack_i}
                               - {{TRANS_ID_BITS{1'b0}}, commit_pop};
        end
    end

    // Entry payload
    always_ff @(posedge clk_i) begin
        result_q <= result_merged;
        if (issue_ack_i) begin
            rd_q[tail_q] <= issue_rd_i;
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the issue stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -Wno-fatal -f sources.f --top-module tb_issue_stage
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_issue_stage > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Test failures found" "$LOG"; then
    echo "Simulation reported failures"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi
if ! grep -q "All tests passed!" "$LOG"; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0

// ==== sources.f ====
logic/issue_pkg.sv
logic/regfile.sv
logic/scoreboard.sv
logic/issue_read_operands.sv
logic/issue_stage.sv
tb/tb_issue_stage.sv

// ==== tb/issue_stim.txt ====
// Columns are op rd rs1 rs2 imm use_imm hold exp and imm and exp are hex
// Op 0 add 1 sub 2 and 3 xor 4 mul 6 drain 7 flush
0 1 0 0 10 1 0 10
0 2 0 0 3 1 0 3
1 3 1 2 0 0 0 d
4 4 3 2 0 0 0 27
3 5 4 0 ff 1 0 d8
2 6 5 1 0 0 0 10
0 0 1 0 100 1 0 110
0 7 0 1 0 0 0 10
4 8 7 0 5 1 0 50
1 8 8 0 1 1 0 4f
0 9 8 8 0 0 0 9e
0 10 0 0 a 1 40 a
0 11 10 0 1 1 0 b
4 12 11 11 0 0 0 79
3 13 12 10 0 0 0 73
0 14 13 9 0 0 0 111
6 0 0 0 0 0 0 0
0 15 0 0 77 1 40 77
4 1 15 2 0 0 0 165
7 0 0 0 0 0 0 0
0 16 1 15 0 0 0 10
1 17 16 0 11 1 0 ffffffff
3 18 17 0 0 0 0 ffffffff
4 19 18 3 0 0 0 fffffff3

// ==== tb/tb_issue_stage.sv ====
// Testbench for the issue stage with FU, commit and reference register models
`timescale 1ns/1ns

module tb_issue_stage;
    import issue_pkg::*;

    logic                                    clk;
    logic                                    rst;
    logic                                    flush;
    logic                                    dec_valid;
    logic [OP_BITS-1:0]                      op;
    logic [REG_ADDR_BITS-1:0]                rd, rs1, rs2;
    logic [XLEN-1:0]                         imm;
    logic                                    use_imm;
    logic                                    alu_ready, mul_ready;
    logic [NR_WB_PORTS-1:0]                  wt_valid;
    logic [NR_WB_PORTS-1:0][TRANS_ID_BITS-1:0] wb_tid;
    logic [NR_WB_PORTS-1:0][XLEN-1:0]        wb_data;
    logic                                    commit_ack;
    logic                                    sb_full, stall, dec_ack, alu_valid, mul_valid;
    logic [OP_BITS-1:0]                      fu_op;
    logic [XLEN-1:0]                         opnd_a, opnd_b, commit_result;
    logic [TRANS_ID_BITS-1:0]                fu_tid, commit_tid;
    logic                                    commit_valid;
    logic [REG_ADDR_BITS-1:0]                commit_rd;

    // Stimulus columns op rd rs1 rs2 imm use_imm hold exp
    logic [31:0] stim [64][8];
    int          n_lines;
    logic [31:0] lcg_state;
    int          cyc, hold_cnt, outstanding;
    bit          commit_en, saw_full, disp_pending, accepted;
    logic [XLEN-1:0] cur_exp;
    logic [XLEN-1:0] spec_regs [NR_REGS];
    logic [XLEN-1:0] arch_regs [NR_REGS];
    logic [TRANS_ID_BITS-1:0] next_tid, disp_tid;
    logic [OP_BITS-1:0]       disp_op;
    logic [XLEN-1:0]          disp_a, disp_b;
    // Expected commits in program order
    logic [REG_ADDR_BITS-1:0] cq_rd[$];
    logic [XLEN-1:0]          cq_res[$];
    logic [TRANS_ID_BITS-1:0] cq_tid[$];
    // Results still inside the FUs
    int                       wb_port_q[$];
    int                       wb_due_q[$];
    logic [TRANS_ID_BITS-1:0] wb_tid_q[$];
    logic [XLEN-1:0]          wb_data_q[$];

    // Commit stage acks whenever it is not holding
    assign commit_ack = commit_en & commit_valid;

    issue_stage i_dut (
        .clk_i (clk), .rst_i (rst), .flush_i (flush),
        .sb_full_o (sb_full), .stall_issue_o (stall),
        .decoded_valid_i (dec_valid), .op_i (op), .rd_i (rd), .rs1_i (rs1), .rs2_i (rs2),
        .imm_i (imm), .use_imm_i (use_imm), .decoded_ack_o (dec_ack),
        .alu_ready_i (alu_ready), .mul_ready_i (mul_ready),
        .alu_valid_o (alu_valid), .mul_valid_o (mul_valid), .fu_op_o (fu_op),
        .operand_a_o (opnd_a), .operand_b_o (opnd_b), .trans_id_o (fu_tid),
        .wt_valid_i (wt_valid), .trans_id_i (wb_tid), .wbdata_i (wb_data),
        .commit_valid_o (commit_valid), .commit_rd_o (commit_rd),
        .commit_result_o (commit_result), .commit_trans_id_o (commit_tid),
        .commit_ack_i (commit_ack)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [XLEN-1:0] apply_op(input logic [OP_BITS-1:0] f,
                                                 input logic [XLEN-1:0] a,
                                                 input logic [XLEN-1:0] b);
        case (f)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_XOR:  return a ^ b;
            OP_MUL:  return a * b;
            default: return 'x;
        endcase
    endfunction

    // Youngest uncommitted producer of src has not written back yet
    function automatic bit producer_pending(input logic [REG_ADDR_BITS-1:0] src);
        bit                       found;
        logic [TRANS_ID_BITS-1:0] tid;
        found = 0;
        tid   = '0;
        if (src == '0)
            return 0;
        for (int i = 0; i < cq_rd.size(); i++) begin
            if (cq_rd[i] == src) begin
                found = 1;
                tid   = cq_tid[i];
            end
        end
        if (!found)
            return 0;
        for (int i = 0; i < wb_tid_q.size(); i++) begin
            if (wb_tid_q[i] == tid)
                return 1;
        end
        return 0;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("error %s: expected 0x%08h, actual 0x%08h", name, exp, act);
            $display("Test failures found");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic load_stim();
        int    fd;
        int    n;
        string line;
        n  = 0;
        fd = $fopen("tb/issue_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file tb/issue_stim.txt");
            $display("Test failures found");
            $fatal(1, "no stimulus");
        end
        while (!$feof(fd)) begin
            if ($fgets(line, fd) != 0) begin
                // Comment lines do not match the format and are skipped
                if ($sscanf(line, "%d %d %d %d %h %d %d %h", stim[n][0], stim[n][1],
                            stim[n][2], stim[n][3], stim[n][4], stim[n][5],
                            stim[n][6], stim[n][7]) == 8) begin
                    n++;
                end
            end
        end
        $fclose(fd);
        if (n == 0) begin
            $display("The stimulus file holds no instruction lines");
            $display("Test failures found");
            $fatal(1, "empty stimulus");
        end
        n_lines = n;
    endtask

    // One clock cycle that checks dispatch, drives at the falling edge and samples handshakes
    task automatic run_cycle(input int idx, input bit do_flush);
        int              p;
        int              k;
        int              delay;
        bit              exp_ack;
        logic [31:0]     rnd;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] r;
        @(negedge clk);
        cyc++;
        check("alu_valid", disp_pending && disp_op != OP_MUL, alu_valid);
        check("mul_valid", disp_pending && disp_op == OP_MUL, mul_valid);
        if (disp_pending) begin
            check("fu_op", disp_op, fu_op);
            check("operand_a", disp_a, opnd_a);
            check("operand_b", disp_b, opnd_b);
            check("fu trans_id", disp_tid, fu_tid);
            rnd   = lcg_next();
            delay = (disp_op == OP_MUL) ? 2 + int'(rnd[17:16]) : 1 + int'(rnd[17:16]) % 3;
            wb_port_q.push_back((disp_op == OP_MUL) ? 1 : 0);
            wb_due_q.push_back(cyc + delay);
            wb_tid_q.push_back(fu_tid);
            wb_data_q.push_back(apply_op(fu_op, opnd_a, opnd_b));
            disp_pending = 0;
        end

        // ------------------------------
        // Drive
        // ------------------------------
        if (do_flush) begin
            wb_port_q.delete();
            wb_due_q.delete();
            wb_tid_q.delete();
            wb_data_q.delete();
        end
        flush     = do_flush;
        dec_valid = (idx >= 0);
        if (idx >= 0) begin
            op      = stim[idx][0][OP_BITS-1:0];
            rd      = stim[idx][1][REG_ADDR_BITS-1:0];
            rs1     = stim[idx][2][REG_ADDR_BITS-1:0];
            rs2     = stim[idx][3][REG_ADDR_BITS-1:0];
            imm     = stim[idx][4];
            use_imm = stim[idx][5][0];
            cur_exp = stim[idx][7];
        end
        rnd       = lcg_next();
        alu_ready = (rnd[19:18] != 2'b00);
        mul_ready = (rnd[21:20] != 2'b00);
        wt_valid  = '0;
        for (p = 0; p < NR_WB_PORTS; p++) begin
            for (k = 0; k < wb_due_q.size(); k++) begin
                if (!wt_valid[p] && wb_port_q[k] == p && wb_due_q[k] <= cyc) begin
                    wt_valid[p] = 1'b1;
                    wb_tid[p]   = wb_tid_q[k];
                    wb_data[p]  = wb_data_q[k];
                    wb_port_q.delete(k);
                    wb_due_q.delete(k);
                    wb_tid_q.delete(k);
                    wb_data_q.delete(k);
                end
            end
        end
        commit_en = (hold_cnt == 0);
        if (hold_cnt > 0)
            hold_cnt--;
        #2;

        // ------------------------------
        // Sample
        // ------------------------------
        check("sb_full", outstanding == NR_SB_ENTRIES, sb_full);
        // Room, no flush, target FU ready and no source waiting on a writeback
        exp_ack = (outstanding != NR_SB_ENTRIES) && !flush
                  && ((op == OP_MUL) ? mul_ready : alu_ready)
                  && !producer_pending(rs1)
                  && (use_imm || !producer_pending(rs2));
        check("decoded_ack", exp_ack, dec_ack);
        check("stall_issue", dec_valid && !exp_ack, stall);
        if (sb_full)
            saw_full = 1;
        if (commit_valid) begin
            check("commit_valid with nothing outstanding", 1, cq_rd.size() > 0);
            if (commit_ack) begin
                check("commit rd", cq_rd[0], commit_rd);
                check("commit result", cq_res[0], commit_result);
                check("commit trans_id", cq_tid[0], commit_tid);
                if (cq_rd[0] != '0)
                    arch_regs[cq_rd[0]] = cq_res[0];
                void'(cq_rd.pop_front());
                void'(cq_res.pop_front());
                void'(cq_tid.pop_front());
                outstanding--;
            end
        end
        accepted = dec_valid && dec_ack;
        if (accepted) begin
            a = spec_regs[rs1];
            b = use_imm ? imm : spec_regs[rs2];
            r = apply_op(op, a, b);
            check("model result against stim", cur_exp, r);
            if (rd != '0)
                spec_regs[rd] = r;
            disp_pending = 1;
            disp_op      = op;
            disp_a       = a;
            disp_b       = b;
            disp_tid     = next_tid;
            cq_rd.push_back(rd);
            cq_res.push_back(r);
            cq_tid.push_back(next_tid);
            next_tid++;
            outstanding++;
        end
        // Roll the model back to the committed state
        if (do_flush) begin
            spec_regs = arch_regs;
            cq_rd.delete();
            cq_res.delete();
            cq_tid.delete();
            outstanding = 0;
            next_tid    = '0;
        end
    endtask

    initial begin : watchdog
        wait (n_lines > 0);
        repeat (n_lines * 200) @(posedge clk);
        $display("Timeout after %0d cycles, the instruction stream never drained", n_lines * 200);
        $display("Test failures found");
        $fatal(1, "watchdog expired");
    end

    initial begin
        rst       = 1'b1;
        flush     = 1'b0;
        dec_valid = 1'b0;
        op        = '0;
        rd        = '0;
        rs1       = '0;
        rs2       = '0;
        imm       = '0;
        use_imm   = 1'b0;
        alu_ready = 1'b0;
        mul_ready = 1'b0;
        wt_valid  = '0;
        wb_tid    = '0;
        wb_data   = '0;
        commit_en = 1'b0;
        lcg_state = 32'hf0de_c5e4;
        cyc = 0;
        hold_cnt = 0;
        outstanding = 0;
        next_tid = '0;
        for (int i = 0; i < NR_REGS; i++) begin
            spec_regs[i] = '0;
            arch_regs[i] = '0;
        end
        load_stim();
        repeat (3) @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < n_lines; i++) begin
            if (stim[i][6] > hold_cnt)
                hold_cnt = stim[i][6];
            if (stim[i][0] == 7) begin
                run_cycle(-1, 1'b1);
            end else if (stim[i][0] == 6) begin
                while (outstanding != 0 || disp_pending)
                    run_cycle(-1, 1'b0);
            end else begin
                do begin
                    run_cycle(i, 1'b0);
                end while (!accepted);
            end
        end
        while (outstanding != 0 || disp_pending)
            run_cycle(-1, 1'b0);
        check("scoreboard reached full", 1, saw_full);
        $display("All tests passed!");
        $finish;
    end

endmodule
